// ==== all.f ====
alu_pkg.sv
operand_select.sv
int_alu.sv
seq_multiplier.sv
seq_divider.sv
exec_unit.sv
tb_clock_gen.sv
tb_exec_assert.sv
tb_exec_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the execute unit regression with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_exec_unit -o sim_exec_unit
./obj_dir/sim_exec_unit | tee sim.log

if grep -q "Regression failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failure"

// ==== tb_exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exec_unit;

    logic             clk;
    logic             rst_n;
    logic             flush;
    logic             issue_valid;
    alu_pkg::issue_t  issue;
    logic             busy;
    logic             result_valid;
    alu_pkg::result_t result;

    logic [31:0]      rng_state = 32'h4719;
    int               cycle = 0;
    int               errors = 0;
    int               checks = 0;
    int               issued = 0;

    // expected values per tag and the issue order of tags and due cycles
    alu_pkg::xlen_t   exp_by_tag [32][$];
    alu_pkg::tag_t    order_q[$];
    int               due_q[$];

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    exec_unit #(
        .MUL_STEPS (64)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // corner values mixed with random words
    function automatic alu_pkg::xlen_t pick_value();
        logic [31:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0: return '0;
            3'd1: return '1;
            3'd2: return {1'b1, 63'b0};
            3'd3: return {56'b0, r[31:24]};
            3'd4: return {32'b0, next_rand()};
            default: return {next_rand(), next_rand()};
        endcase
    endfunction

    function automatic logic multi_op(input alu_pkg::alu_op_t op);
        return op inside {alu_pkg::op_mul, alu_pkg::op_div, alu_pkg::op_divu,
                          alu_pkg::op_rem, alu_pkg::op_remu};
    endfunction

    function automatic alu_pkg::alu_op_t single_op();
        logic [4:0] code;
        code = 5'(next_rand() % 32'd15);
        return alu_pkg::alu_op_t'(code);
    endfunction

    function automatic alu_pkg::alu_op_t div_op(input logic [1:0] sel);
        case (sel)
            2'd0: return alu_pkg::op_div;
            2'd1: return alu_pkg::op_divu;
            2'd2: return alu_pkg::op_rem;
            default: return alu_pkg::op_remu;
        endcase
    endfunction

    function automatic alu_pkg::issue_t random_issue(input alu_pkg::alu_op_t op);
        alu_pkg::issue_t it;
        logic [31:0] r;
        r = next_rand();
        it.op = op;
        it.tag = r[4:0];
        it.word = r[5];
        it.sel_a = r[6] ? alu_pkg::sel_a_rs1 : alu_pkg::sel_a_pc;
        case (r[9:8])
            2'd1: it.sel_b = alu_pkg::sel_b_rs2;
            2'd2: it.sel_b = alu_pkg::sel_b_csr;
            default: it.sel_b = alu_pkg::sel_b_imm;
        endcase
        it.pc = pick_value();
        it.rs1 = pick_value();
        it.rs2 = pick_value();
        it.csr = pick_value();
        it.imm = pick_value();
        return it;
    endfunction

    // rs1 and rs2 as full 64-bit operands
    function automatic alu_pkg::issue_t direct_issue(input alu_pkg::alu_op_t op,
                                                     input alu_pkg::xlen_t a,
                                                     input alu_pkg::xlen_t b);
        alu_pkg::issue_t it;
        it = random_issue(op);
        it.word = 1'b0;
        it.sel_a = alu_pkg::sel_a_rs1;
        it.sel_b = alu_pkg::sel_b_rs2;
        it.rs1 = a;
        it.rs2 = b;
        return it;
    endfunction

    function automatic alu_pkg::xlen_t div_model(input alu_pkg::alu_op_t op,
                                                 input alu_pkg::xlen_t a,
                                                 input alu_pkg::xlen_t b);
        logic           sgn;
        logic           want_rem;
        alu_pkg::xlen_t ua;
        alu_pkg::xlen_t ub;
        alu_pkg::xlen_t q;
        alu_pkg::xlen_t r;
        sgn = (op == alu_pkg::op_div) || (op == alu_pkg::op_rem);
        want_rem = (op == alu_pkg::op_rem) || (op == alu_pkg::op_remu);
        if (b == '0) begin
            return want_rem ? a : '1;
        end
        ua = (sgn && a[63]) ? ~a + 64'd1 : a;
        ub = (sgn && b[63]) ? ~b + 64'd1 : b;
        q = ua / ub;
        r = ua % ub;
        // overflow case wraps back to the most negative value
        if (sgn && (a[63] ^ b[63])) q = ~q + 64'd1;
        if (sgn && a[63]) r = ~r + 64'd1;
        return want_rem ? r : q;
    endfunction

    function automatic alu_pkg::xlen_t expect_value(input alu_pkg::issue_t it);
        alu_pkg::xlen_t a;
        alu_pkg::xlen_t b;
        alu_pkg::xlen_t flip;
        logic [31:0]    lo;
        int             sh;
        if (it.sel_a == alu_pkg::sel_a_rs1) begin
            a = it.word ? {32'b0, it.rs1[31:0]} : it.rs1;
        end else begin
            a = it.pc;
        end
        case (it.sel_b)
            alu_pkg::sel_b_rs2: b = it.rs2;
            alu_pkg::sel_b_csr: b = it.csr;
            default: b = it.imm;
        endcase
        flip = {1'b1, 63'b0};
        sh = int'(b[5:0]);
        case (it.op)
            alu_pkg::op_add: return a + b;
            alu_pkg::op_sub: return a - b;
            alu_pkg::op_pass_a: return a;
            alu_pkg::op_pass_b: return b;
            alu_pkg::op_xor: return a ^ b;
            alu_pkg::op_or: return a | b;
            alu_pkg::op_and: return a & b;
            alu_pkg::op_sll: return a << sh;
            alu_pkg::op_srl: return a >> sh;
            alu_pkg::op_sra: begin
                if (it.word) begin
                    lo = (a[31:0] >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'b0);
                    return {32'b0, lo};
                end
                return (a >> sh) | (a[63] ? ~({64{1'b1}} >> sh) : 64'b0);
            end
            // signed order by flipping the sign bit
            alu_pkg::op_slt: return {63'b0, (a ^ flip) < (b ^ flip)};
            alu_pkg::op_sltu: return {63'b0, a < b};
            alu_pkg::op_eq: return {63'b0, a == b};
            alu_pkg::op_ge: return {63'b0, (a ^ flip) >= (b ^ flip)};
            alu_pkg::op_geu: return {63'b0, a >= b};
            alu_pkg::op_mul: return a * b;
            default: return div_model(it.op, a, b);
        endcase
    endfunction

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic abort(input string why);
        $display("timeout: %s", why);
        $display("Regression failed");
        $finish;
    endtask

    task automatic take_result();
        alu_pkg::tag_t want_tag;
        int            due;
        if (order_q.size() == 0) begin
            errors++;
            $display("unexpected result_valid at %0t with no operation outstanding", $time);
            return;
        end
        want_tag = order_q.pop_front();
        due = due_q.pop_front();
        check("result tag", 64'(result.tag), 64'(want_tag));
        if (exp_by_tag[result.tag].size() == 0) begin
            errors++;
            $display("result at %0t carries tag %0d with nothing expected", $time, result.tag);
        end else begin
            check("result value", result.value, exp_by_tag[result.tag].pop_front());
        end
        if (due >= 0) begin
            check("result cycle", 64'(cycle), 64'(due));
        end
    endtask

    // advance to the falling edge where inputs change
    task automatic tick();
        @(negedge clk);
        issue_valid = 1'b0;
        flush = 1'b0;
        if (result_valid) begin
            take_result();
        end
    endtask

    task automatic send(input alu_pkg::issue_t it);
        issue_valid = 1'b1;
        issue = it;
        order_q.push_back(it.tag);
        exp_by_tag[it.tag].push_back(expect_value(it));
        due_q.push_back(multi_op(it.op) ? -1 : cycle + 2);
        issued++;
    endtask

    task automatic drop_last(input alu_pkg::tag_t tag);
        void'(order_q.pop_back());
        void'(due_q.pop_back());
        void'(exp_by_tag[tag].pop_back());
    endtask

    task automatic drain(input int limit);
        int n;
        n = 0;
        while (order_q.size() != 0) begin
            if (n == limit) abort("result_valid did not arrive for a single-cycle op");
            tick();
            n++;
        end
    endtask

    // busy stays high up to the result and drops one cycle later
    task automatic wait_unit(input int limit);
        int n;
        n = 0;
        while (order_q.size() != 0) begin
            if (n == limit) abort("result_valid did not arrive for a multi-cycle op");
            tick();
            check("busy while pending", 64'(busy), 64'd1);
            n++;
        end
        tick();
        check("busy after result", 64'(busy), 64'd0);
    endtask

    task automatic report(input string name, input int err0, input int ops0);
        $display("%s: %0d ops, %0d errors", name, issued - ops0, errors - err0);
    endtask

    initial begin
        alu_pkg::issue_t  it;
        alu_pkg::alu_op_t dop;
        logic [31:0]      r;
        int               n;
        int               k;
        int               err0;
        int               ops0;
        issue_valid = 1'b0;
        flush = 1'b0;
        issue = '0;
        n = 0;
        while (rst_n !== 1'b1) begin
            if (n == 100) abort("reset was never released");
            tick();
            n++;
        end

        err0 = errors;
        ops0 = issued;
        for (int i = 0; i < 300; i++) begin
            tick();
            r = next_rand();
            if (r[1:0] != 2'd0) send(random_issue(single_op()));
        end
        drain(20);
        report("test 1 single-cycle ops", err0, ops0);

        err0 = errors;
        ops0 = issued;
        for (int i = 0; i < 64; i++) begin
            tick();
            send(random_issue(single_op()));
        end
        drain(20);
        report("test 2 single-cycle latency", err0, ops0);

        err0 = errors;
        ops0 = issued;
        for (int i = 0; i < 40; i++) begin
            tick();
            if (i[0]) send(random_issue(alu_pkg::op_mul));
            else send(direct_issue(alu_pkg::op_mul, pick_value(), pick_value()));
            wait_unit(200);
        end
        report("test 3 multiply", err0, ops0);

        err0 = errors;
        ops0 = issued;
        for (int i = 0; i < 80; i++) begin
            tick();
            dop = div_op(2'(i));
            if (i < 4) send(direct_issue(dop, pick_value(), '0));
            else if (i < 8) send(direct_issue(dop, {1'b1, 63'b0}, '1));
            else send(direct_issue(dop, pick_value(), pick_value()));
            wait_unit(200);
        end
        report("test 4 divide and remainder", err0, ops0);

        err0 = errors;
        ops0 = issued;
        for (int i = 0; i < 16; i++) begin
            tick();
            dop = i[0] ? div_op(2'(next_rand() % 32'd4)) : alu_pkg::op_mul;
            // nonzero divisor keeps the divider running
            it = direct_issue(dop, pick_value(), pick_value() | 64'd1);
            send(it);
            k = 1 + int'(next_rand() % 32'd20);
            repeat (k) tick();
            flush = 1'b1;
            drop_last(it.tag);
            tick();
            check("busy after flush", 64'(busy), 64'd0);
            repeat (90) tick();
            send(random_issue(single_op()));
            drain(20);
            tick();
            send(direct_issue(dop, pick_value(), pick_value()));
            wait_unit(200);
        end
        report("test 5 flush", err0, ops0);

        $display("checks %0d, ops %0d, errors %0d", checks, issued, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_exec_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exec_assert (
    input logic clk,
    input logic rst_n,
    input logic issue_valid,
    input logic busy,
    input logic result_valid,
    input logic ret_multi
);

    // result strobe stays low while in reset
    a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !result_valid)
        else $error("result_valid high during reset");

    // issuer must hold off while busy
    a_no_issue_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !issue_valid)
        else $error("issue_valid high while busy");

    // pending tag returns only once
    a_single_multi_result: assert property (@(posedge clk) disable iff (!rst_n)
        (result_valid && ret_multi) |=> !(result_valid && ret_multi))
        else $error("multi-cycle result strobe held for two cycles");

endmodule

bind exec_unit tb_exec_assert u_exec_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue_valid  (issue_valid),
    .busy         (busy),
    .result_valid (result_valid),
    .ret_multi    (ret_multi_q)
);

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held for 16 cycles, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit #(
    parameter int MUL_STEPS = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             issue_valid,
    input  alu_pkg::issue_t  issue,
    output logic             busy,
    output logic             result_valid,
    output alu_pkg::result_t result
);

    logic              op_valid;
    alu_pkg::operand_t operand;
    alu_pkg::xlen_t    alu_value;

    logic              op_multi;
    logic              mul_start;
    logic              div_start;
    logic              mul_done;
    logic              div_done;
    alu_pkg::xlen_t    mul_product;
    alu_pkg::xlen_t    div_value;
    logic              unit_done;

    logic              pend_q;
    logic              busy_q;
    logic              ret_multi_q;
    alu_pkg::tag_t     pend_tag;

    operand_select u_operand_select (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue       (issue),
        .op_valid    (op_valid),
        .operand     (operand)
    );

    int_alu u_int_alu (
        .operand (operand),
        .value   (alu_value)
    );

    assign op_multi = alu_pkg::is_multi_cycle(operand.op);
    assign mul_start = op_valid && !flush && (operand.op == alu_pkg::op_mul);
    assign div_start = op_valid && !flush && op_multi && (operand.op != alu_pkg::op_mul);

    seq_multiplier #(
        .MUL_STEPS (MUL_STEPS)
    ) u_seq_multiplier (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .start   (mul_start),
        .a       (operand.a),
        .b       (operand.b),
        .done    (mul_done),
        .product (mul_product)
    );

    seq_divider u_seq_divider (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .start (div_start),
        .op    (operand.op),
        .a     (operand.a),
        .b     (operand.b),
        .done  (div_done),
        .value (div_value)
    );

    assign unit_done = pend_q && (mul_done || div_done);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            ret_multi_q <= 1'b0;
            pend_q <= 1'b0;
            busy_q <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            ret_multi_q <= 1'b0;
            if (flush) begin
                pend_q <= 1'b0;
                busy_q <= 1'b0;
            end else begin
                if (op_valid && !op_multi) begin
                    result_valid <= 1'b1;
                end
                if (op_valid && op_multi) begin
                    pend_q <= 1'b1;
                end
                if (unit_done) begin
                    result_valid <= 1'b1;
                    ret_multi_q <= 1'b1;
                    pend_q <= 1'b0;
                end
                // held through the cycle of the multi-cycle result
                if (issue_valid && alu_pkg::is_multi_cycle(issue.op)) begin
                    busy_q <= 1'b1;
                end else if (ret_multi_q) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid && op_multi) begin
            pend_tag <= operand.tag;
        end
        if (op_valid && !op_multi) begin
            result <= '{tag: operand.tag, value: alu_value};
        end else if (unit_done) begin
            result <= '{tag: pend_tag, value: mul_done ? mul_product : div_value};
        end
    end

    assign busy = busy_q;

endmodule

`default_nettype wire

// ==== seq_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module seq_divider (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             start,
    input  alu_pkg::alu_op_t op,
    input  alu_pkg::xlen_t   a,
    input  alu_pkg::xlen_t   b,
    output logic             done,
    output alu_pkg::xlen_t   value
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_fix,
        st_done
    } state_t;

    state_t         state;
    logic [5:0]     count;

    logic           is_signed;
    logic           want_rem;
    logic           neg_a;
    logic           neg_b;
    logic           div_zero;
    alu_pkg::xlen_t mag_a;
    alu_pkg::xlen_t mag_b;

    // working registers
    alu_pkg::xlen_t quo;
    alu_pkg::xlen_t rem;
    alu_pkg::xlen_t dvs;
    logic           neg_q;
    logic           neg_r;
    logic           rem_sel;
    alu_pkg::xlen_t value_q;

    logic [64:0]    shifted;
    logic [64:0]    diff;

    assign is_signed = (op == alu_pkg::op_div) || (op == alu_pkg::op_rem);
    assign want_rem = (op == alu_pkg::op_rem) || (op == alu_pkg::op_remu);
    assign neg_a = is_signed && a[63];
    assign neg_b = is_signed && b[63];
    assign mag_a = neg_a ? -a : a;
    assign mag_b = neg_b ? -b : b;
    assign div_zero = (b == '0);

    // one restoring step, partial remainder needs a 65th bit
    assign shifted = {rem, quo[63]};
    assign diff = shifted - {1'b0, dvs};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            count <= '0;
        end else if (flush) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        // zero divisor skips the iteration
                        state <= div_zero ? st_done : st_run;
                        count <= '0;
                    end
                end
                st_run: begin
                    if (count == 6'd63) begin
                        state <= st_fix;
                    end
                    count <= count + 1'b1;
                end
                st_fix:  state <= st_done;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            quo <= mag_a;
            rem <= '0;
            dvs <= mag_b;
            neg_q <= neg_a ^ neg_b;
            neg_r <= neg_a;
            rem_sel <= want_rem;
            // riscv divide by zero results
            value_q <= want_rem ? a : '1;
        end else if (state == st_run) begin
            if (!diff[64]) begin
                rem <= diff[63:0];
                quo <= {quo[62:0], 1'b1};
            end else begin
                rem <= shifted[63:0];
                quo <= {quo[62:0], 1'b0};
            end
        end else if (state == st_fix) begin
            // remainder follows the dividend sign
            if (rem_sel) begin
                value_q <= neg_r ? -rem : rem;
            end else begin
                value_q <= neg_q ? -quo : quo;
            end
        end
    end

    assign done = (state == st_done);
    assign value = value_q;

endmodule

`default_nettype wire

// ==== seq_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module seq_multiplier #(
    parameter int MUL_STEPS = 64
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           flush,
    input  logic           start,
    input  alu_pkg::xlen_t a,
    input  alu_pkg::xlen_t b,
    output logic           done,
    output alu_pkg::xlen_t product
);

    // multiplier bits retired per cycle
    localparam int BITS = alu_pkg::XLEN / MUL_STEPS;
    localparam int CNT_W = $clog2(MUL_STEPS + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_done
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] count;
    alu_pkg::xlen_t   mcand;
    alu_pkg::xlen_t   mplier;
    alu_pkg::xlen_t   acc;
    alu_pkg::xlen_t   step_sum;

    // add the shifted multiplicand for each set multiplier bit
    always_comb begin
        step_sum = acc;
        for (int i = 0; i < BITS; i++) begin
            if (mplier[i]) begin
                step_sum = step_sum + (mcand << i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            count <= '0;
        end else if (flush) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_run;
                        count <= '0;
                    end
                end
                st_run: begin
                    if (count == CNT_W'(MUL_STEPS - 1)) begin
                        state <= st_done;
                    end
                    count <= count + 1'b1;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            mcand <= a;
            mplier <= b;
            acc <= '0;
        end else if (state == st_run) begin
            acc <= step_sum;
            mcand <= mcand << BITS;
            mplier <= mplier >> BITS;
        end
    end

    assign done = (state == st_done);
    assign product = acc;

endmodule

`default_nettype wire

// ==== int_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_alu (
    input  alu_pkg::operand_t operand,
    output alu_pkg::xlen_t    value
);

    alu_pkg::xlen_t a;
    alu_pkg::xlen_t b;
    logic [5:0]     shamt;
    logic [31:0]    sra_word;
    logic           lt_signed;
    logic           lt_unsigned;

    assign a = operand.a;
    assign b = operand.b;
    assign shamt = b[5:0];

    // 32-bit arithmetic shift, result zero-extended
    assign sra_word = $signed(a[31:0]) >>> shamt;

    assign lt_signed = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (operand.op)
            alu_pkg::op_add: begin
                value = a + b;
            end
            alu_pkg::op_sub: begin
                value = a - b;
            end
            alu_pkg::op_pass_a: value = a;
            alu_pkg::op_pass_b: value = b;
            alu_pkg::op_xor:    value = a ^ b;
            alu_pkg::op_or:     value = a | b;
            alu_pkg::op_and:    value = a & b;
            alu_pkg::op_sll:    value = a << shamt;
            alu_pkg::op_srl:    value = a >> shamt;
            alu_pkg::op_sra: begin
                if (operand.word) begin
                    value = {32'b0, sra_word};
                end else begin
                    value = $signed(a) >>> shamt;
                end
            end
            // compares give 0 or 1
            alu_pkg::op_slt: begin
                value = alu_pkg::xlen_t'(lt_signed);
            end
            alu_pkg::op_sltu: begin
                value = alu_pkg::xlen_t'(lt_unsigned);
            end
            alu_pkg::op_eq: begin
                value = alu_pkg::xlen_t'(a == b);
            end
            alu_pkg::op_ge: begin
                value = alu_pkg::xlen_t'(!lt_signed);
            end
            alu_pkg::op_geu: begin
                value = alu_pkg::xlen_t'(!lt_unsigned);
            end
            // multi-cycle ops are not handled here
            default: value = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== operand_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_select (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              issue_valid,
    input  alu_pkg::issue_t   issue,
    output logic              op_valid,
    output alu_pkg::operand_t operand
);

    alu_pkg::xlen_t a_sel;
    alu_pkg::xlen_t b_sel;
    alu_pkg::xlen_t rs1_ext;

    // word flag keeps only the low half of rs1
    assign rs1_ext = issue.word ? {32'b0, issue.rs1[31:0]} : issue.rs1;

    always_comb begin
        case (issue.sel_a)
            alu_pkg::sel_a_rs1: a_sel = rs1_ext;
            default:            a_sel = issue.pc;
        endcase
    end

    always_comb begin
        case (issue.sel_b)
            alu_pkg::sel_b_rs2: b_sel = issue.rs2;
            alu_pkg::sel_b_csr: b_sel = issue.csr;
            default:            b_sel = issue.imm;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= issue_valid && !flush;
        end
    end

    // operand payload, qualified by op_valid downstream
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            operand <= '{op: issue.op, tag: issue.tag, word: issue.word,
                         a: a_sel, b: b_sel};
        end
    end

endmodule

`default_nettype wire

// ==== alu_pkg.sv ====
`default_nettype none

package alu_pkg;

    localparam int XLEN = 64;
    localparam int TAG_W = 5;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [TAG_W-1:0] tag_t;

    typedef enum logic [4:0] {
        op_add,
        op_sub,
        op_pass_a,
        op_pass_b,
        op_xor,
        op_or,
        op_and,
        op_sll,
        op_srl,
        op_sra,
        op_slt,
        op_sltu,
        op_eq,
        op_ge,
        op_geu,
        op_mul,
        op_div,
        op_divu,
        op_rem,
        op_remu
    } alu_op_t;

    // operand a source
    typedef enum logic [1:0] {
        sel_a_pc  = 2'd0,
        sel_a_rs1 = 2'd1
    } sel_a_t;

    // operand b source, matches the issuer encoding
    typedef enum logic [1:0] {
        sel_b_imm = 2'd0,
        sel_b_rs2 = 2'd1,
        sel_b_csr = 2'd2
    } sel_b_t;

    typedef struct packed {
        alu_op_t op;
        tag_t    tag;
        logic    word;
        sel_a_t  sel_a;
        sel_b_t  sel_b;
        xlen_t   pc;
        xlen_t   rs1;
        xlen_t   rs2;
        xlen_t   csr;
        xlen_t   imm;
    } issue_t;

    typedef struct packed {
        alu_op_t op;
        tag_t    tag;
        logic    word;
        xlen_t   a;
        xlen_t   b;
    } operand_t;

    typedef struct packed {
        tag_t  tag;
        xlen_t value;
    } result_t;

    // ops served by the multiplier or the divider
    function automatic logic is_multi_cycle(alu_op_t op);
        return op inside {op_mul, op_div, op_divu, op_rem, op_remu};
    endfunction

endpackage

`default_nettype wire
